// File: verilog/arf_pkg.sv
//--------------------
// array geometry and observation sizes shared by the register file RTL
// import with a wildcard inside each module body that needs these
//--------------------
`default_nettype none

package arf_pkg;

  // --------------------
  // array geometry
  // --------------------

  // number of entries in the register file
  localparam int arf_depth = 16;

  // address width, enough to reach every entry
  localparam int arf_addr_w = $clog2(arf_depth);

  // width of one data word
  localparam int arf_data_w = 32;

  // one byte lane is eight bits wide
  localparam int arf_byte_w = 8;

  // one write enable per byte lane
  localparam int arf_be_w = arf_data_w / arf_byte_w;

  // --------------------
  // scan observation
  // --------------------

  // observed pins are write address, write enable, byte enables,
  // read address and read enable, packed from bit 0 in that order
  localparam int arf_obs_pin_num = arf_addr_w + 1 + arf_be_w + arf_addr_w + 1;

  // each observation flop folds this many pin bits through one XOR
  localparam int arf_obs_xor_size = 3;

  // group count rounded up, the last group takes what is left over
  localparam int arf_obs_flop_num =
    (arf_obs_pin_num + arf_obs_xor_size - 1) / arf_obs_xor_size;

endpackage

`default_nettype wire

// File: verilog/arf_wr_if.sv
//--------------------
// write port bundle between the top level, the storage array and the observation tap
//--------------------
`timescale 1ns/10ps
`default_nettype none

interface arf_wr_if;

  import arf_pkg::*;

  // write strobe, taken in the cycle it is presented
  logic                  wr_en;
  logic [arf_addr_w-1:0] wr_addr;
  // one enable bit per byte lane of wr_data
  logic [arf_be_w-1:0]   wr_be;
  logic [arf_data_w-1:0] wr_data;

  // driver side, filled from the top level pins
  modport src
  (
    output wr_en, wr_addr, wr_be, wr_data
  );

  // storage side, also feeds the scan write-through path
  modport sink
  (
    input wr_en, wr_addr, wr_be, wr_data
  );

  // observation side only needs address and control, never the payload
  modport mon
  (
    input wr_en, wr_addr, wr_be
  );

endinterface

`default_nettype wire

// File: verilog/arf_obs_flops.sv
//--------------------
// XOR-folding observation flops that make memory address and control pins visible to scan
//--------------------
`timescale 1ns/10ps
`default_nettype none

module arf_obs_flops
#(
  parameter int OBS_PIN_NUM  = 3,
  parameter int OBS_XOR_SIZE = 3
)
(
  input  logic                                                    clock_b,
  input  logic [OBS_PIN_NUM-1:0]                                  obs_in,
  output logic [(OBS_PIN_NUM + OBS_XOR_SIZE - 1) / OBS_XOR_SIZE - 1:0] obs_out
);

  // one folded bit per observation flop
  logic [$bits(obs_out)-1:0] fold;

  // pin i lands in group i / OBS_XOR_SIZE, so groups start at bit 0
  // and the last group simply collects the leftover bits
  always_comb
  begin
    fold = '0;
    for (int i = 0; i < OBS_PIN_NUM; i++)
    begin
      fold[i / OBS_XOR_SIZE] ^= obs_in[i];
    end
  end

  // --------------------
  // capture stage
  // --------------------

  // obs_out shows the folded pins of the previous cycle
  always_ff @(posedge clock_b)
  begin
    obs_out <= fold;
  end

endmodule

`default_nettype wire

// File: verilog/arf_storage.sv
//--------------------
// 16x32 register file with byte-masked write, registered read and scan write-through
//--------------------
`timescale 1ns/10ps
`default_nettype none

module arf_storage
(
  input  logic                             clock_b,
  input  logic                             rst_n,
  input  logic                             scan_mode,
  arf_wr_if.sink                           wr,
  input  logic                             rd_en,
  input  logic [arf_pkg::arf_addr_w-1:0]   rd_addr,
  output logic [arf_pkg::arf_data_w-1:0]   rd_data
);

  import arf_pkg::*;

  // the entry array itself, one word per address
  logic [arf_data_w-1:0] mem [arf_depth];

  // qualified write strobe, scan mode keeps the array contents frozen
  logic wr_fire;

  // value the read register loads when a read is taken
  logic [arf_data_w-1:0] rd_next;

  // --------------------
  // write path
  // --------------------

  assign wr_fire = wr.wr_en & ~scan_mode;

  // each lane is written only when its byte enable is set,
  // lanes with a clear enable keep their old contents
  always_ff @(posedge clock_b)
  begin
    if (wr_fire)
    begin
      for (int b = 0; b < arf_be_w; b++)
      begin
        if (wr.wr_be[b])
        begin
          mem[wr.wr_addr][b*arf_byte_w +: arf_byte_w] <=
            wr.wr_data[b*arf_byte_w +: arf_byte_w];
        end
      end
    end
  end

  // --------------------
  // read path
  // --------------------

  // in scan mode the array is bypassed and the write data goes straight
  // to the read register, independent of either address
  // outside scan mode the array is read before this edge's write lands,
  // so a read and write to one address in one cycle returns old data
  assign rd_next = scan_mode ? wr.wr_data : mem[rd_addr];

  // rd_data only changes on a taken read and holds otherwise
  always_ff @(posedge clock_b)
  begin
    if (!rst_n)
    begin
      rd_data <= '0;
    end
    else if (rd_en)
    begin
      rd_data <= rd_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/arf_top.sv
//--------------------
// register file top level with plain pins, wires the write bundle, storage and scan observation
//--------------------
`timescale 1ns/10ps
`default_nettype none

module arf_top
(
  input  logic                                 clock_b,
  input  logic                                 rst_n,
  input  logic                                 scan_mode,
  // write port
  input  logic                                 wr_en,
  input  logic [arf_pkg::arf_addr_w-1:0]       wr_addr,
  input  logic [arf_pkg::arf_be_w-1:0]         wr_be,
  input  logic [arf_pkg::arf_data_w-1:0]       wr_data,
  // read port
  input  logic                                 rd_en,
  input  logic [arf_pkg::arf_addr_w-1:0]       rd_addr,
  output logic [arf_pkg::arf_data_w-1:0]       rd_data,
  // folded address and control pins for scan
  output logic [arf_pkg::arf_obs_flop_num-1:0] obs_out
);

  import arf_pkg::*;

  // address and control pins, wr_addr at bit 0 and rd_en at the top
  logic [arf_obs_pin_num-1:0] obs_word;

  // --------------------
  // write bundle
  // --------------------

  arf_wr_if wr_if_i ();

  // source side of the bundle is just the top level pins
  assign wr_if_i.wr_en   = wr_en;
  assign wr_if_i.wr_addr = wr_addr;
  assign wr_if_i.wr_be   = wr_be;
  assign wr_if_i.wr_data = wr_data;

  // --------------------
  // storage
  // --------------------

  arf_storage storage_i
  (
    .clock_b   (clock_b),
    .rst_n     (rst_n),
    .scan_mode (scan_mode),
    .wr        (wr_if_i.sink),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  // --------------------
  // scan observation
  // --------------------

  // monitored write controls are taken from the bundle, read controls
  // from the pins, concatenated MSB first so wr_addr ends up at bit 0
  assign obs_word = {rd_en, rd_addr, wr_if_i.wr_be, wr_if_i.wr_en, wr_if_i.wr_addr};

  arf_obs_flops
  #(
    .OBS_PIN_NUM  (arf_obs_pin_num),
    .OBS_XOR_SIZE (arf_obs_xor_size)
  )
  obs_i
  (
    .clock_b (clock_b),
    .obs_in  (obs_word),
    .obs_out (obs_out)
  );

endmodule

`default_nettype wire

// File: verification/arf_checker.sv
//--------------------
// concurrent assertions on the storage block read path, bound into every arf_storage
//--------------------
`timescale 1ns/10ps
`default_nettype none

module arf_checker
(
  input  logic                           clock_b,
  input  logic                           rst_n,
  input  logic                           scan_mode,
  input  logic                           rd_en,
  input  logic [arf_pkg::arf_data_w-1:0] wr_data,
  input  logic [arf_pkg::arf_data_w-1:0] rd_data
);

  import arf_pkg::*;

  // running count of assertion failures, read by the testbench at the end
  int assert_errors = 0;

  // a cycle without a read leaves the read register untouched
  hold_without_read: assert property (
    @(posedge clock_b) disable iff (!rst_n)
    !rd_en |=> $stable(rd_data)
  )
  else
  begin
    assert_errors++;
    $error("rd_data changed after a cycle with rd_en low");
  end

  // scan write-through returns the write data of the read cycle
  scan_write_through: assert property (
    @(posedge clock_b) disable iff (!rst_n)
    (scan_mode && rd_en) |=> (rd_data == $past(wr_data))
  )
  else
  begin
    assert_errors++;
    $error("scan read did not return the previous cycle's wr_data");
  end

  // read enable and scan mode must be driven once reset is released
  controls_known: assert property (
    @(posedge clock_b)
    rst_n |-> !$isunknown({rd_en, scan_mode})
  )
  else
  begin
    assert_errors++;
    $error("rd_en or scan_mode is unknown after reset");
  end

endmodule

// attach one checker to each storage instance, write data comes from the bundle
bind arf_storage arf_checker checker_i
(
  .clock_b   (clock_b),
  .rst_n     (rst_n),
  .scan_mode (scan_mode),
  .rd_en     (rd_en),
  .wr_data   (wr.wr_data),
  .rd_data   (rd_data)
);

`default_nettype wire

// File: verification/arf_tb.sv
//--------------------
// directed testbench for the register file top level
// runs write, byte mask, hold, scan and observation tests against a shadow array
//--------------------
`timescale 1ns/10ps
`default_nettype none

module arf_tb;

  import arf_pkg::*;

  // clock period in ns
  localparam int clk_period = 8;

  // rough cycle budget of all tests, reset included
  localparam int test_cycles = 8 + 40 + 40 + 20 + 30 + 20;

  // watchdog limit, twice the budget plus a fixed margin
  localparam int timeout_ns = (2 * test_cycles + 100) * clk_period;

  logic                        clock_b;
  logic                        rst_n;
  logic                        scan_mode;
  logic                        wr_en;
  logic [arf_addr_w-1:0]       wr_addr;
  logic [arf_be_w-1:0]         wr_be;
  logic [arf_data_w-1:0]       wr_data;
  logic                        rd_en;
  logic [arf_addr_w-1:0]       rd_addr;
  logic [arf_data_w-1:0]       rd_data;
  logic [arf_obs_flop_num-1:0] obs_out;

  // reference copy of the array contents
  logic [arf_data_w-1:0] shadow [arf_depth];

  logic [31:0] lcg_state;
  int          value_errors;
  int          check_count;

  arf_top dut_i
  (
    .clock_b   (clock_b),
    .rst_n     (rst_n),
    .scan_mode (scan_mode),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_be     (wr_be),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .obs_out   (obs_out)
  );

  initial
  begin
    clock_b = 1'b0;
    forever #(clk_period / 2) clock_b = ~clock_b;
  end

  // --------------------
  // helpers
  // --------------------

  // numerical recipes LCG, deterministic from the fixed seed
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // a set enable takes the new byte, a clear one keeps the old byte
  function automatic logic [arf_data_w-1:0] merge_bytes(
    input logic [arf_data_w-1:0] old_word,
    input logic [arf_data_w-1:0] new_word,
    input logic [arf_be_w-1:0]   be
  );
    logic [arf_data_w-1:0] result;
    result = old_word;
    for (int b = 0; b < arf_be_w; b++)
    begin
      if (be[b])
      begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // observation word is wr_addr, wr_en, wr_be, rd_addr, rd_en from bit 0,
  // folded in groups of three with the last group holding two bits
  function automatic logic [4:0] fold_obs(input logic [13:0] w);
    logic [4:0] folded;
    folded[0] = w[0] ^ w[1] ^ w[2];
    folded[1] = w[3] ^ w[4] ^ w[5];
    folded[2] = w[6] ^ w[7] ^ w[8];
    folded[3] = w[9] ^ w[10] ^ w[11];
    folded[4] = w[12] ^ w[13];
    return folded;
  endfunction

  task automatic check_value(
    input string                 name,
    input logic [arf_data_w-1:0] expected,
    input logic [arf_data_w-1:0] actual
  );
    check_count++;
    if (actual !== expected)
    begin
      value_errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // step past the next rising edge, outputs are settled 1 ns later
  task automatic tick();
    @(posedge clock_b);
    #1;
  endtask

  task automatic idle_inputs();
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_be   = '0;
    wr_data = '0;
    rd_en   = 1'b0;
    rd_addr = '0;
  endtask

  task automatic write_word(
    input logic [arf_addr_w-1:0] addr,
    input logic [arf_be_w-1:0]   be,
    input logic [arf_data_w-1:0] data
  );
    idle_inputs();
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_be   = be;
    wr_data = data;
    tick();
    shadow[addr] = merge_bytes(shadow[addr], data, be);
    idle_inputs();
  endtask

  task automatic read_check(input string name, input logic [arf_addr_w-1:0] addr);
    idle_inputs();
    rd_en   = 1'b1;
    rd_addr = addr;
    tick();
    idle_inputs();
    check_value(name, shadow[addr], rd_data);
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic test_full_write_read();
    check_value("reset_value", '0, rd_data);
    for (int a = 0; a < arf_depth; a++)
    begin
      write_word(a[arf_addr_w-1:0], '1, next_rand());
    end
    for (int a = 0; a < arf_depth; a++)
    begin
      read_check("full_write_read", a[arf_addr_w-1:0]);
    end
  endtask

  task automatic test_byte_mask();
    logic [31:0] r;
    for (int i = 0; i < arf_depth; i++)
    begin
      r = next_rand();
      write_word(r[arf_addr_w-1:0], r[11:8], next_rand());
    end
    for (int a = 0; a < arf_depth; a++)
    begin
      read_check("byte_mask", a[arf_addr_w-1:0]);
    end
  endtask

  task automatic test_read_hold();
    logic [arf_data_w-1:0] held;
    logic [arf_data_w-1:0] old_word;
    logic [arf_data_w-1:0] new_word;
    read_check("read_hold_setup", 4'd5);
    held = shadow[5];
    // keep writing entry 5 and moving rd_addr while no read is taken
    for (int i = 0; i < 4; i++)
    begin
      new_word = next_rand();
      wr_en    = 1'b1;
      wr_addr  = 4'd5;
      wr_be    = '1;
      wr_data  = new_word;
      rd_addr  = i[arf_addr_w-1:0];
      tick();
      shadow[5] = new_word;
      check_value("read_hold", held, rd_data);
    end
    // read and write to one address in one cycle sees the old word
    old_word = shadow[9];
    new_word = next_rand();
    idle_inputs();
    wr_en   = 1'b1;
    wr_addr = 4'd9;
    wr_be   = '1;
    wr_data = new_word;
    rd_en   = 1'b1;
    rd_addr = 4'd9;
    tick();
    idle_inputs();
    check_value("read_during_write", old_word, rd_data);
    shadow[9] = new_word;
    read_check("read_after_write", 4'd9);
    read_check("held_writes_landed", 4'd5);
  endtask

  task automatic test_scan_through();
    logic [arf_data_w-1:0] sent;
    logic [31:0]           r;
    scan_mode = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      r       = next_rand();
      sent    = next_rand();
      wr_en   = 1'b1;
      wr_addr = r[3:0];
      wr_be   = r[7:4];
      wr_data = sent;
      rd_en   = 1'b1;
      rd_addr = r[11:8];
      tick();
      check_value("scan_write_through", sent, rd_data);
    end
    idle_inputs();
    scan_mode = 1'b0;
    // every entry must be untouched by the scan cycles
    for (int a = 0; a < arf_depth; a++)
    begin
      read_check("scan_blocked_write", a[arf_addr_w-1:0]);
    end
  endtask

  task automatic test_obs_flops();
    logic [31:0] r;
    logic [13:0] word;
    // scan mode keeps the array frozen while control pins toggle at random
    scan_mode = 1'b1;
    for (int i = 0; i < 12; i++)
    begin
      r       = next_rand();
      wr_addr = r[3:0];
      wr_en   = r[4];
      wr_be   = r[8:5];
      rd_addr = r[12:9];
      rd_en   = r[13];
      wr_data = next_rand();
      word    = {rd_en, rd_addr, wr_be, wr_en, wr_addr};
      tick();
      check_value("obs_flops", {27'd0, fold_obs(word)}, {27'd0, obs_out});
    end
    idle_inputs();
    scan_mode = 1'b0;
    tick();
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial
  begin
    lcg_state    = 32'he9d1;
    value_errors = 0;
    check_count  = 0;
    rst_n        = 1'b0;
    scan_mode    = 1'b0;
    idle_inputs();
    repeat (8) tick();
    rst_n = 1'b1;

    test_full_write_read();
    test_byte_mask();
    test_read_hold();
    test_scan_through();
    test_obs_flops();

    $display("checks %0d, value errors %0d, assertion errors %0d",
             check_count, value_errors, dut_i.storage_i.checker_i.assert_errors);
    if (value_errors == 0 && dut_i.storage_i.checker_i.assert_errors == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog stops a stuck run
  initial
  begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns before the tests finished", timeout_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: arf_top.f
verilog/arf_pkg.sv
verilog/arf_wr_if.sv
verilog/arf_obs_flops.sv
verilog/arf_storage.sv
verilog/arf_top.sv
verification/arf_checker.sv
verification/arf_tb.sv

// File: Bender.yml
package:
  name: arf

sources:
  # synthesizable register file
  - files:
      - verilog/arf_pkg.sv
      - verilog/arf_wr_if.sv
      - verilog/arf_obs_flops.sv
      - verilog/arf_storage.sv
      - verilog/arf_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - verification/arf_checker.sv
      - verification/arf_tb.sv
